// File: logic/rv_pkg.sv
package rv_pkg;

   ////////////////////////////////////////////////////////////
   // Basic types
   ////////////////////////////////////////////////////////////

   typedef logic [31:0] word_t;
   typedef logic [4:0]  reg_idx_t;
   typedef logic [31:0] instr_t;
   typedef logic [11:0] csr_addr_t;

   typedef enum logic [3:0] {
      ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR, ALU_SRL, ALU_SRA,
      ALU_OR, ALU_AND, ALU_EQ, ALU_NE, ALU_LT, ALU_GE, ALU_LTU, ALU_GEU
   } alu_op_e;

   typedef enum logic [1:0] {MEM_NONE, MEM_LOAD, MEM_STORE} mem_op_e;

   typedef enum logic [2:0] {WB_ALU, WB_MEM, WB_PC4, WB_CSR, WB_IMM} wb_sel_e;

   typedef enum logic [1:0] {CSR_NONE, CSR_WRITE, CSR_SET} csr_op_e;

   typedef enum logic [2:0] {
      PC_PLUS4, PC_BRANCH, PC_JAL, PC_JALR, PC_TRAP, PC_MEPC
   } pc_sel_e;

   // Control bundle, decoder to datapath
   typedef struct packed {
      alu_op_e alu_op;
      logic    a_from_pc;
      logic    b_from_imm;
      logic    reg_write;
      wb_sel_e wb_sel;
      mem_op_e mem_op;
      logic    is_branch;
      logic    is_jal;
      logic    is_jalr;
      csr_op_e csr_op;
      logic    csr_src_reg;
      logic    illegal;
      logic    ecall;
      logic    mret;
   } ctrl_t;

   ////////////////////////////////////////////////////////////
   // Encodings
   ////////////////////////////////////////////////////////////

   localparam logic [6:0] OPC_LUI    = 7'b0110111;
   localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
   localparam logic [6:0] OPC_JAL    = 7'b1101111;
   localparam logic [6:0] OPC_JALR   = 7'b1100111;
   localparam logic [6:0] OPC_BRANCH = 7'b1100011;
   localparam logic [6:0] OPC_LOAD   = 7'b0000011;
   localparam logic [6:0] OPC_STORE  = 7'b0100011;
   localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
   localparam logic [6:0] OPC_OP     = 7'b0110011;
   localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

   localparam instr_t INSTR_ECALL = 32'h0000_0073;
   localparam instr_t INSTR_MRET  = 32'h3020_0073;

   localparam csr_addr_t CSR_MTVEC  = 12'h305;
   localparam csr_addr_t CSR_MEPC   = 12'h341;
   localparam csr_addr_t CSR_MCAUSE = 12'h342;

   localparam word_t CAUSE_ILLEGAL        = 32'd2;
   localparam word_t CAUSE_LOAD_MISALIGN  = 32'd4;
   localparam word_t CAUSE_STORE_MISALIGN = 32'd6;
   localparam word_t CAUSE_ECALL          = 32'd11;

   // Memory map
   localparam word_t RESET_PC       = 32'h8000_0000;
   localparam word_t TRAP_VEC_RESET = 32'h8000_0100;
   localparam word_t IO_BASE        = 32'h1000_0000;
   localparam word_t MTIME_ADDR     = 32'h0200_BFF8;
   localparam int    RAM_WORDS      = 256;
   localparam int    RAM_IDX_W      = $clog2(RAM_WORDS);

endpackage

// File: logic/data_bus_if.sv
`timescale 1ns/1ps

interface data_bus_if;
   import rv_pkg::*;

   word_t   addr;
   word_t   wdata;
   word_t   rdata;
   mem_op_e op;

   // Core drives the request, RAM answers in the same cycle
   modport core (output addr, output wdata, output op, input rdata);
   modport mem (input addr, input wdata, input op, output rdata);

endinterface

// File: logic/reg_file.sv
`timescale 1ns/1ps

module reg_file (
   input  logic             clk,
   input  logic             rst,
   input  rv_pkg::reg_idx_t rs1_i,
   input  rv_pkg::reg_idx_t rs2_i,
   input  rv_pkg::reg_idx_t rd_i,
   input  logic             we_i,
   input  rv_pkg::word_t    wdata_i,
   output rv_pkg::word_t    rdata1_o,
   output rv_pkg::word_t    rdata2_o
);
   import rv_pkg::*;

   word_t regs [32];

   // x0 reads as zero whatever the array holds
   assign rdata1_o = (rs1_i == '0) ? '0 : regs[rs1_i];
   assign rdata2_o = (rs2_i == '0) ? '0 : regs[rs2_i];

   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < 32; i++) begin
            regs[i] <= '0;
         end
      end else if (we_i && (rd_i != '0)) begin
         regs[rd_i] <= wdata_i;
      end
   end

endmodule

// File: logic/alu.sv
`timescale 1ns/1ps

module alu (
   input  rv_pkg::alu_op_e op_i,
   input  rv_pkg::word_t   a_i,
   input  rv_pkg::word_t   b_i,
   output rv_pkg::word_t   result_o
);
   import rv_pkg::*;

   logic [4:0] shamt;
   logic       lt_s;
   logic       lt_u;

   assign shamt = b_i[4:0];
   assign lt_s  = $signed(a_i) < $signed(b_i);
   assign lt_u  = a_i < b_i;

   always_comb begin
      case (op_i)
         ALU_ADD:  result_o = a_i + b_i;
         ALU_SUB:  result_o = a_i - b_i;
         ALU_SLL:  result_o = a_i << shamt;
         ALU_SLT:  result_o = {31'b0, lt_s};
         ALU_SLTU: result_o = {31'b0, lt_u};
         ALU_XOR:  result_o = a_i ^ b_i;
         ALU_SRL:  result_o = a_i >> shamt;
         ALU_SRA:  result_o = $unsigned($signed(a_i) >>> shamt);
         ALU_OR:   result_o = a_i | b_i;
         ALU_AND:  result_o = a_i & b_i;
         // Branch conditions, taken flag in bit 0
         ALU_EQ:   result_o = {31'b0, a_i == b_i};
         ALU_NE:   result_o = {31'b0, a_i != b_i};
         ALU_LT:   result_o = {31'b0, lt_s};
         ALU_GE:   result_o = {31'b0, !lt_s};
         ALU_LTU:  result_o = {31'b0, lt_u};
         ALU_GEU:  result_o = {31'b0, !lt_u};
         default:  result_o = '0;
      endcase
   end

endmodule

// File: logic/decoder.sv
`timescale 1ns/1ps

module decoder (
   input  rv_pkg::instr_t    instr_i,
   output rv_pkg::ctrl_t     ctrl_o,
   output rv_pkg::word_t     imm_o,
   output rv_pkg::reg_idx_t  rs1_o,
   output rv_pkg::reg_idx_t  rs2_o,
   output rv_pkg::reg_idx_t  rd_o,
   output rv_pkg::csr_addr_t csr_addr_o
);
   import rv_pkg::*;

   logic [6:0] opcode;
   logic [2:0] funct3;
   logic [6:0] funct7;
   ctrl_t      c;

   assign opcode     = instr_i[6:0];
   assign funct3     = instr_i[14:12];
   assign funct7     = instr_i[31:25];
   assign rs1_o      = instr_i[19:15];
   assign rs2_o      = instr_i[24:20];
   assign rd_o       = instr_i[11:7];
   assign csr_addr_o = instr_i[31:20];

   // Shared by OP and OP-IMM, alt is the funct7 bit 5 selector
   function automatic alu_op_e arith_op(input logic [2:0] f3, input logic alt);
      case (f3)
         3'b000:  arith_op = alt ? ALU_SUB : ALU_ADD;
         3'b001:  arith_op = ALU_SLL;
         3'b010:  arith_op = ALU_SLT;
         3'b011:  arith_op = ALU_SLTU;
         3'b100:  arith_op = ALU_XOR;
         3'b101:  arith_op = alt ? ALU_SRA : ALU_SRL;
         3'b110:  arith_op = ALU_OR;
         default: arith_op = ALU_AND;
      endcase
   endfunction

   ////////////////////////////////////////////////////////////
   // Immediate generation
   ////////////////////////////////////////////////////////////

   always_comb begin
      case (opcode)
         OPC_LUI, OPC_AUIPC: imm_o = {instr_i[31:12], 12'b0};
         OPC_JAL:    imm_o = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20],
                              instr_i[30:21], 1'b0};
         OPC_BRANCH: imm_o = {{20{instr_i[31]}}, instr_i[7], instr_i[30:25],
                              instr_i[11:8], 1'b0};
         OPC_STORE:  imm_o = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
         default:    imm_o = {{20{instr_i[31]}}, instr_i[31:20]};
      endcase
   end

   ////////////////////////////////////////////////////////////
   // Control decode
   ////////////////////////////////////////////////////////////

   always_comb begin
      c = '0;
      case (opcode)
         OPC_LUI: begin
            c.reg_write = 1'b1;
            c.wb_sel    = WB_IMM;
         end
         OPC_AUIPC: begin
            c.a_from_pc  = 1'b1;
            c.b_from_imm = 1'b1;
            c.reg_write  = 1'b1;
         end
         OPC_JAL: begin
            c.is_jal    = 1'b1;
            c.reg_write = 1'b1;
            c.wb_sel    = WB_PC4;
         end
         OPC_JALR: begin
            c.is_jalr    = 1'b1;
            c.b_from_imm = 1'b1;
            c.reg_write  = 1'b1;
            c.wb_sel     = WB_PC4;
            c.illegal    = funct3 != 3'b000;
         end
         OPC_BRANCH: begin
            c.is_branch = 1'b1;
            case (funct3)
               3'b000:  c.alu_op = ALU_EQ;
               3'b001:  c.alu_op = ALU_NE;
               3'b100:  c.alu_op = ALU_LT;
               3'b101:  c.alu_op = ALU_GE;
               3'b110:  c.alu_op = ALU_LTU;
               3'b111:  c.alu_op = ALU_GEU;
               default: c.illegal = 1'b1;
            endcase
         end
         OPC_LOAD, OPC_STORE: begin
            // Word accesses only
            c.b_from_imm = 1'b1;
            c.illegal    = funct3 != 3'b010;
            if (opcode == OPC_LOAD) begin
               c.mem_op    = MEM_LOAD;
               c.reg_write = 1'b1;
               c.wb_sel    = WB_MEM;
            end else begin
               c.mem_op = MEM_STORE;
            end
         end
         OPC_OP_IMM: begin
            c.b_from_imm = 1'b1;
            c.reg_write  = 1'b1;
            c.alu_op     = arith_op(funct3, funct3 == 3'b101 && funct7[5]);
            if (funct3 == 3'b001) begin
               c.illegal = funct7 != 7'b0;
            end else if (funct3 == 3'b101) begin
               c.illegal = (funct7 & 7'b1011111) != 7'b0;
            end
         end
         OPC_OP: begin
            c.reg_write = 1'b1;
            c.alu_op    = arith_op(funct3, funct7[5]);
            if (funct3 == 3'b000 || funct3 == 3'b101) begin
               c.illegal = (funct7 & 7'b1011111) != 7'b0;
            end else begin
               c.illegal = funct7 != 7'b0;
            end
         end
         OPC_SYSTEM: begin
            if (funct3 == 3'b001 || funct3 == 3'b010) begin
               c.csr_op      = (funct3 == 3'b001) ? CSR_WRITE : CSR_SET;
               c.csr_src_reg = 1'b1;
               c.reg_write   = 1'b1;
               c.wb_sel      = WB_CSR;
               c.illegal     = !(csr_addr_o inside {CSR_MTVEC, CSR_MEPC, CSR_MCAUSE});
            end else begin
               c.ecall   = instr_i == INSTR_ECALL;
               c.mret    = instr_i == INSTR_MRET;
               c.illegal = !(c.ecall || c.mret);
            end
         end
         default: c.illegal = 1'b1;
      endcase

      // An illegal word keeps only its flag
      if (c.illegal) begin
         c         = '0;
         c.illegal = 1'b1;
      end
   end

   assign ctrl_o = c;

endmodule

// File: logic/csr_unit.sv
`timescale 1ns/1ps

module csr_unit (
   input  logic              clk,
   input  logic              rst,
   input  rv_pkg::csr_op_e   op_i,
   input  rv_pkg::csr_addr_t addr_i,
   input  rv_pkg::word_t     wdata_i,
   output rv_pkg::word_t     rdata_o,
   input  logic              trap_i,
   input  rv_pkg::word_t     cause_i,
   input  rv_pkg::word_t     pc_i,
   input  logic              mret_i,
   output rv_pkg::word_t     mtvec_o,
   output rv_pkg::word_t     mepc_o,
   output rv_pkg::word_t     mtime_o
);
   import rv_pkg::*;

   word_t mtvec_q;
   word_t mepc_q;
   word_t mcause_q;
   word_t mtime_q;
   word_t csr_new;

   always_comb begin
      case (addr_i)
         CSR_MTVEC:  rdata_o = mtvec_q;
         CSR_MEPC:   rdata_o = mepc_q;
         CSR_MCAUSE: rdata_o = mcause_q;
         default:    rdata_o = '0;
      endcase
   end

   // Read-modify-write value
   assign csr_new = (op_i == CSR_SET) ? (rdata_o | wdata_i) : wdata_i;

   always_ff @(posedge clk) begin
      if (rst) begin
         mtvec_q  <= TRAP_VEC_RESET;
         mepc_q   <= '0;
         mcause_q <= '0;
         mtime_q  <= '0;
      end else begin
         mtime_q <= mtime_q + 32'd1;
         if (trap_i) begin
            mepc_q   <= pc_i;
            mcause_q <= cause_i;
         end else if (mret_i) begin
            // Return closes the trap, no cause pending
            mcause_q <= '0;
         end else if (op_i != CSR_NONE) begin
            case (addr_i)
               CSR_MTVEC:  mtvec_q  <= {csr_new[31:2], 2'b00};
               CSR_MEPC:   mepc_q   <= {csr_new[31:2], 2'b00};
               CSR_MCAUSE: mcause_q <= csr_new;
               default:    mcause_q <= mcause_q;
            endcase
         end
      end
   end

   assign mtvec_o = mtvec_q;
   assign mepc_o  = mepc_q;
   assign mtime_o = mtime_q;

endmodule

// File: logic/data_ram.sv
`timescale 1ns/1ps

module data_ram (
   input logic    clk,
   data_bus_if.mem bus
);
   import rv_pkg::*;

   word_t                mem [RAM_WORDS];
   logic [RAM_IDX_W-1:0] idx;

   // Word index, byte offset dropped
   assign idx = bus.addr[RAM_IDX_W+1:2];

   assign bus.rdata = mem[idx];

   always_ff @(posedge clk) begin
      if (bus.op == MEM_STORE) begin
         mem[idx] <= bus.wdata;
      end
   end

endmodule

// File: logic/rv_core.sv
`timescale 1ns/1ps

module rv_core (
   input  logic           clk,
   input  logic           rst,
   output rv_pkg::word_t  pc_o,
   input  rv_pkg::instr_t instr_i,
   data_bus_if.core       dbus,
   output logic           io_we_o,
   output rv_pkg::word_t  io_addr_o,
   output rv_pkg::word_t  io_wdata_o
);
   import rv_pkg::*;

   word_t     pc_q;
   word_t     pc_next;
   word_t     pc_plus4;
   word_t     pc_rel;
   pc_sel_e   pc_sel;
   ctrl_t     ctrl;
   word_t     imm;
   reg_idx_t  rs1;
   reg_idx_t  rs2;
   reg_idx_t  rd;
   csr_addr_t csr_addr;
   word_t     rs1_data;
   word_t     rs2_data;
   word_t     alu_result;
   word_t     wb_data;
   word_t     load_data;
   word_t     csr_rdata;
   word_t     csr_wdata;
   word_t     mtvec;
   word_t     mepc;
   word_t     mtime;
   word_t     trap_cause;
   logic      is_io;
   logic      is_timer;
   logic      is_ram;
   logic      misalign;
   logic      trap;

   decoder u_decoder (
      .instr_i    (instr_i),
      .ctrl_o     (ctrl),
      .imm_o      (imm),
      .rs1_o      (rs1),
      .rs2_o      (rs2),
      .rd_o       (rd),
      .csr_addr_o (csr_addr)
   );

   reg_file u_reg_file (
      .clk      (clk),
      .rst      (rst),
      .rs1_i    (rs1),
      .rs2_i    (rs2),
      .rd_i     (rd),
      .we_i     (ctrl.reg_write && !trap),
      .wdata_i  (wb_data),
      .rdata1_o (rs1_data),
      .rdata2_o (rs2_data)
   );

   alu u_alu (
      .op_i     (ctrl.alu_op),
      .a_i      (ctrl.a_from_pc ? pc_q : rs1_data),
      .b_i      (ctrl.b_from_imm ? imm : rs2_data),
      .result_o (alu_result)
   );

   assign csr_wdata = ctrl.csr_src_reg ? rs1_data : {27'b0, rs1};

   csr_unit u_csr_unit (
      .clk     (clk),
      .rst     (rst),
      .op_i    (ctrl.csr_op),
      .addr_i  (csr_addr),
      .wdata_i (csr_wdata),
      .rdata_o (csr_rdata),
      .trap_i  (trap),
      .cause_i (trap_cause),
      .pc_i    (pc_q),
      .mret_i  (ctrl.mret),
      .mtvec_o (mtvec),
      .mepc_o  (mepc),
      .mtime_o (mtime)
   );

   ////////////////////////////////////////////////////////////
   // Traps and data address decode
   ////////////////////////////////////////////////////////////

   assign misalign = (ctrl.mem_op != MEM_NONE) && (alu_result[1:0] != 2'b00);
   assign trap     = ctrl.illegal || ctrl.ecall || misalign;

   always_comb begin
      if (ctrl.illegal) begin
         trap_cause = CAUSE_ILLEGAL;
      end else if (ctrl.ecall) begin
         trap_cause = CAUSE_ECALL;
      end else if (ctrl.mem_op == MEM_STORE) begin
         trap_cause = CAUSE_STORE_MISALIGN;
      end else begin
         trap_cause = CAUSE_LOAD_MISALIGN;
      end
   end

   assign is_io    = alu_result >= IO_BASE;
   assign is_timer = alu_result == MTIME_ADDR;
   assign is_ram   = !is_io && !is_timer;

   // Nothing retires to memory while held in reset
   assign dbus.addr  = alu_result;
   assign dbus.wdata = rs2_data;
   assign dbus.op    = (rst || trap || !is_ram) ? MEM_NONE : ctrl.mem_op;

   assign io_we_o    = !rst && !trap && is_io && (ctrl.mem_op == MEM_STORE);
   assign io_addr_o  = alu_result;
   assign io_wdata_o = rs2_data;

   // IO reads back as zero
   always_comb begin
      if (is_timer) begin
         load_data = mtime;
      end else if (is_ram) begin
         load_data = dbus.rdata;
      end else begin
         load_data = '0;
      end
   end

   always_comb begin
      case (ctrl.wb_sel)
         WB_MEM:  wb_data = load_data;
         WB_PC4:  wb_data = pc_plus4;
         WB_CSR:  wb_data = csr_rdata;
         WB_IMM:  wb_data = imm;
         default: wb_data = alu_result;
      endcase
   end

   ////////////////////////////////////////////////////////////
   // Next PC
   ////////////////////////////////////////////////////////////

   assign pc_plus4 = pc_q + 32'd4;
   assign pc_rel   = pc_q + imm;

   always_comb begin
      if (trap) begin
         pc_sel = PC_TRAP;
      end else if (ctrl.is_branch && alu_result[0]) begin
         pc_sel = PC_BRANCH;
      end else if (ctrl.is_jal) begin
         pc_sel = PC_JAL;
      end else if (ctrl.is_jalr) begin
         pc_sel = PC_JALR;
      end else if (ctrl.mret) begin
         pc_sel = PC_MEPC;
      end else begin
         pc_sel = PC_PLUS4;
      end

      case (pc_sel)
         PC_TRAP:             pc_next = mtvec;
         PC_BRANCH, PC_JAL:   pc_next = pc_rel;
         PC_JALR:             pc_next = {alu_result[31:1], 1'b0};
         PC_MEPC:             pc_next = mepc;
         default:             pc_next = pc_plus4;
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         pc_q <= RESET_PC;
      end else begin
         pc_q <= pc_next;
      end
   end

   assign pc_o = pc_q;

endmodule

// File: logic/rv_sys.sv
`timescale 1ns/1ps

module rv_sys (
   input  logic        clk,
   input  logic        rst,
   output logic [31:0] pc_o,
   input  logic [31:0] instr_i,
   output logic        io_we_o,
   output logic [31:0] io_addr_o,
   output logic [31:0] io_wdata_o
);

   data_bus_if dbus ();

   rv_core u_rv_core (
      .clk        (clk),
      .rst        (rst),
      .pc_o       (pc_o),
      .instr_i    (instr_i),
      .dbus       (dbus.core),
      .io_we_o    (io_we_o),
      .io_addr_o  (io_addr_o),
      .io_wdata_o (io_wdata_o)
   );

   // Scratch RAM on the core data bus
   data_ram u_data_ram (
      .clk (clk),
      .bus (dbus.mem)
   );

endmodule

// File: dv/rv_sys_properties.sv
`timescale 1ns/1ps

module rv_sys_properties (
   input logic            clk,
   input logic            rst,
   input rv_pkg::word_t   pc_i,
   input logic            io_we_i,
   input rv_pkg::mem_op_e ram_op_i
);
   import rv_pkg::*;

   // Reset keeps the IO port quiet and holds the PC
   reset_io_quiet: assert property (@(posedge clk) rst |-> !io_we_i)
      else $error("IO write enable high while in reset");

   reset_pc_held: assert property (@(posedge clk) rst && $past(rst) |-> pc_i == RESET_PC)
      else $error("PC left the reset address while in reset");

   pc_word_aligned: assert property (@(posedge clk) disable iff (rst) pc_i[1:0] == 2'b00)
      else $error("PC not word aligned");

   // One data target per cycle
   ram_io_exclusive: assert property (@(posedge clk) disable iff (rst)
      !(ram_op_i != MEM_NONE && io_we_i))
      else $error("RAM access and IO store in the same cycle");

endmodule

bind rv_core rv_sys_properties props_inst (
   .clk      (clk),
   .rst      (rst),
   .pc_i     (pc_o),
   .io_we_i  (io_we_o),
   .ram_op_i (dbus.op)
);

// File: dv/tb_rv_sys.sv
`timescale 1ns/1ps

module tb_rv_sys;
   import rv_pkg::*;

   localparam logic [31:0] JUMP_SELF     = 32'h0000_006F;
   localparam logic [31:0] HANDLER_PC    = 32'h8000_0200;
   localparam int          STORE_TIMEOUT = 200;

   logic        clk;
   logic        rst;
   logic [31:0] pc;
   logic [31:0] instr;
   logic        io_we;
   logic [31:0] io_addr;
   logic [31:0] io_wdata;

   // Program address/word pairs and expected IO stores in order
   logic [31:0] prog_addr [$];
   logic [31:0] prog_word [$];
   string       exp_name [$];
   logic [31:0] exp_addr [$];
   logic [31:0] exp_data [$];
   logic [31:0] asm_pc;

   rv_sys rv_sys_inst (
      .clk        (clk),
      .rst        (rst),
      .pc_o       (pc),
      .instr_i    (instr),
      .io_we_o    (io_we),
      .io_addr_o  (io_addr),
      .io_wdata_o (io_wdata)
   );

   always #10 clk = ~clk;

   ////////////////////////////////////////////////////////////
   // Instruction encoders and instruction memory
   ////////////////////////////////////////////////////////////

   function automatic logic [31:0] r_type(input logic [6:0] f7, input int rs2, input int rs1,
                                          input logic [2:0] f3, input int rd);
      return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], OPC_OP};
   endfunction

   function automatic logic [31:0] i_type(input int imm, input int rs1, input logic [2:0] f3,
                                          input int rd, input logic [6:0] opc);
      return {imm[11:0], rs1[4:0], f3, rd[4:0], opc};
   endfunction

   // Word store only
   function automatic logic [31:0] s_type(input int imm, input int rs2, input int rs1);
      return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], OPC_STORE};
   endfunction

   function automatic logic [31:0] b_type(input int imm, input int rs2, input int rs1,
                                          input logic [2:0] f3);
      return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3, imm[4:1], imm[11], OPC_BRANCH};
   endfunction

   function automatic logic [31:0] u_type(input int imm, input int rd, input logic [6:0] opc);
      return {imm[19:0], rd[4:0], opc};
   endfunction

   function automatic logic [31:0] j_type(input int imm, input int rd);
      return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], OPC_JAL};
   endfunction

   // Unknown addresses spin in place
   function automatic logic [31:0] fetch(input logic [31:0] addr);
      logic [31:0] word;
      word = JUMP_SELF;
      foreach (prog_addr[k]) begin
         if (prog_addr[k] == addr) begin
            word = prog_word[k];
         end
      end
      return word;
   endfunction

   always @(pc) begin
      instr = fetch(pc);
   end

   task automatic put(input logic [31:0] word);
      prog_addr.push_back(asm_pc);
      prog_word.push_back(word);
      asm_pc = asm_pc + 32'd4;
   endtask

   // Offsets are relative to the IO_BASE value in x31
   task automatic expect_io(input string name, input logic [31:0] off, input logic [31:0] value);
      exp_name.push_back(name);
      exp_addr.push_back(IO_BASE + off);
      exp_data.push_back(value);
   endtask

   task automatic load_tables();
      logic [31:0] a;
      logic [31:0] t_ill;
      logic [31:0] t_ecall;
      logic [31:0] t_lw;
      asm_pc = RESET_PC;
      put(u_type(IO_BASE >> 12, 31, OPC_LUI));

      // Arithmetic, immediates and write-back
      put(u_type('h12345, 1, OPC_LUI));
      put(s_type('h00, 1, 31));
      expect_io("lui", 'h00, 32'h1234_5000);
      put(i_type('h678, 1, 3'b000, 2, OPC_OP_IMM));
      put(s_type('h04, 2, 31));
      expect_io("addi", 'h04, 32'h1234_5000 + 32'h678);
      put(i_type(-5, 0, 3'b000, 3, OPC_OP_IMM));
      put(r_type(7'b0000000, 3, 2, 3'b000, 4));
      put(s_type('h08, 4, 31));
      expect_io("add", 'h08, 32'h1234_5678 + 32'hFFFF_FFFB);
      put(r_type(7'b0100000, 2, 3, 3'b000, 5));
      put(s_type('h0C, 5, 31));
      expect_io("sub", 'h0C, 32'hFFFF_FFFB - 32'h1234_5678);
      put(i_type(4, 2, 3'b001, 6, OPC_OP_IMM));
      put(s_type('h10, 6, 31));
      expect_io("slli", 'h10, 32'h1234_5678 << 4);
      // -5 shifted right arithmetically by one is -3
      put(i_type('h401, 3, 3'b101, 7, OPC_OP_IMM));
      put(s_type('h14, 7, 31));
      expect_io("srai", 'h14, 32'hFFFF_FFFD);
      put(i_type(28, 3, 3'b101, 8, OPC_OP_IMM));
      put(s_type('h18, 8, 31));
      expect_io("srli", 'h18, 32'hFFFF_FFFB >> 28);
      put(r_type(7'b0000000, 2, 3, 3'b010, 9));
      put(s_type('h1C, 9, 31));
      expect_io("slt", 'h1C, 32'd1);
      put(r_type(7'b0000000, 3, 2, 3'b100, 10));
      put(s_type('h20, 10, 31));
      expect_io("xor", 'h20, 32'h1234_5678 ^ 32'hFFFF_FFFB);
      a = asm_pc;
      put(u_type('h1, 11, OPC_AUIPC));
      put(s_type('h24, 11, 31));
      expect_io("auipc", 'h24, a + 32'h1000);

      // Control flow
      // A wrong path stores x3 to offset 0x7C
      put(b_type(8, 1, 1, 3'b000));
      put(s_type('h7C, 3, 31));
      put(i_type('h11, 0, 3'b000, 12, OPC_OP_IMM));
      put(s_type('h40, 12, 31));
      expect_io("beq_taken", 'h40, 32'h11);
      put(b_type(8, 1, 1, 3'b001));
      put(i_type('h22, 0, 3'b000, 12, OPC_OP_IMM));
      put(s_type('h44, 12, 31));
      expect_io("bne_not_taken", 'h44, 32'h22);
      put(b_type(8, 2, 3, 3'b100));
      put(s_type('h7C, 3, 31));
      put(i_type('h33, 0, 3'b000, 12, OPC_OP_IMM));
      put(s_type('h48, 12, 31));
      expect_io("blt_taken", 'h48, 32'h33);
      put(b_type(8, 3, 2, 3'b111));
      put(i_type('h44, 0, 3'b000, 12, OPC_OP_IMM));
      put(s_type('h4C, 12, 31));
      expect_io("bgeu_not_taken", 'h4C, 32'h44);
      a = asm_pc;
      put(j_type(8, 13));
      put(s_type('h7C, 3, 31));
      put(s_type('h50, 13, 31));
      expect_io("jal_link", 'h50, a + 32'd4);
      a = asm_pc;
      put(u_type(0, 14, OPC_AUIPC));
      put(i_type(12, 14, 3'b000, 15, OPC_JALR));
      put(s_type('h7C, 3, 31));
      put(s_type('h54, 15, 31));
      expect_io("jalr_link", 'h54, a + 32'd8);

      // RAM round trip and then two timer reads four instructions apart
      put(i_type('h100, 0, 3'b000, 16, OPC_OP_IMM));
      put(s_type(0, 2, 16));
      put(i_type(0, 16, 3'b010, 17, OPC_LOAD));
      put(s_type('h60, 17, 31));
      expect_io("ram_round_trip", 'h60, 32'h1234_5678);
      put(u_type((MTIME_ADDR + 32'h8) >> 12, 19, OPC_LUI));
      put(i_type(-8, 19, 3'b010, 18, OPC_LOAD));
      for (int n = 0; n < 3; n++) begin
         put(i_type(0, 0, 3'b000, 0, OPC_OP_IMM));
      end
      put(i_type(-8, 19, 3'b010, 20, OPC_LOAD));
      put(r_type(7'b0100000, 18, 20, 3'b000, 21));
      put(s_type('h64, 21, 31));
      expect_io("mtime_delta", 'h64, 32'd4);

      // Traps that each resume at the next instruction
      put(u_type(HANDLER_PC >> 12, 22, OPC_LUI));
      put(i_type('h200, 22, 3'b000, 22, OPC_OP_IMM));
      put(i_type('h305, 22, 3'b001, 0, OPC_SYSTEM));
      t_ill = asm_pc;
      put(32'hFFFF_FFFF);
      t_ecall = asm_pc;
      put(INSTR_ECALL);
      t_lw = asm_pc;
      put(i_type(1, 16, 3'b010, 23, OPC_LOAD));
      expect_io("illegal_mcause", 'h80, 32'd2);
      expect_io("illegal_mepc", 'h84, t_ill);
      expect_io("ecall_mcause", 'h80, 32'd11);
      expect_io("ecall_mepc", 'h84, t_ecall);
      expect_io("misaligned_lw_mcause", 'h80, 32'd4);
      expect_io("misaligned_lw_mepc", 'h84, t_lw);
      put(i_type('h7A, 0, 3'b000, 24, OPC_OP_IMM));
      put(s_type('h90, 24, 31));
      expect_io("trap_return_done", 'h90, 32'h7A);
      put(JUMP_SELF);

      // Handler reports mcause and mepc and then skips the trapping word
      asm_pc = HANDLER_PC;
      put(i_type('h342, 0, 3'b010, 25, OPC_SYSTEM));
      put(s_type('h80, 25, 31));
      put(i_type('h341, 0, 3'b010, 26, OPC_SYSTEM));
      put(s_type('h84, 26, 31));
      put(i_type(4, 26, 3'b000, 26, OPC_OP_IMM));
      put(i_type('h341, 26, 3'b001, 0, OPC_SYSTEM));
      put(INSTR_MRET);
   endtask

   ////////////////////////////////////////////////////////////
   // Checks
   ////////////////////////////////////////////////////////////

   task automatic stop_with_failure();
      $display("Some tests failed");
      $fatal(1, "Simulation stopped at the first error");
   endtask

   task automatic check_reset_state();
      assert (pc == RESET_PC) else begin
         $display("FAIL reset_state: expected pc_o %h, actual %h", RESET_PC, pc);
         stop_with_failure();
      end
      assert (io_we == 1'b0) else begin
         $display("FAIL reset_state: expected io_we_o 0, actual %b", io_we);
         stop_with_failure();
      end
   endtask

   task automatic run_store_checks();
      int cycles;
      bit seen;
      foreach (exp_name[i]) begin
         seen   = 1'b0;
         cycles = 0;
         while (!seen && cycles < STORE_TIMEOUT) begin
            @(negedge clk);
            seen   = io_we;
            cycles = cycles + 1;
         end
         if (!seen) begin
            $display("Timeout: IO store %s to address %h never came within %0d cycles",
                     exp_name[i], exp_addr[i], STORE_TIMEOUT);
            stop_with_failure();
         end else begin
            assert (io_addr == exp_addr[i]) else begin
               $display("FAIL %s: expected address %h, actual %h",
                        exp_name[i], exp_addr[i], io_addr);
               stop_with_failure();
            end
            assert (io_wdata == exp_data[i]) else begin
               $display("FAIL %s: expected data %h, actual %h",
                        exp_name[i], exp_data[i], io_wdata);
               stop_with_failure();
            end
         end
      end
   endtask

   initial begin
      clk   = 1'b0;
      rst   = 1'b1;
      instr = JUMP_SELF;
      load_tables();

      // PC must still sit at the reset address after three reset cycles
      for (int i = 0; i < 3; i++) begin
         @(posedge clk);
         if (i == 2) begin
            rst <= 1'b0;
         end
         @(negedge clk);
         check_reset_state();
      end

      run_store_checks();
      $display("All tests passed");
      $finish;
   end

endmodule

// File: sources.f
logic/rv_pkg.sv
logic/data_bus_if.sv
logic/reg_file.sv
logic/alu.sv
logic/decoder.sv
logic/csr_unit.sv
logic/data_ram.sv
logic/rv_core.sv
logic/rv_sys.sv
dv/rv_sys_properties.sv
dv/tb_rv_sys.sv

// File: run.sh
#!/bin/sh
# Compile and run the rv_sys testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --assert --top-module tb_rv_sys -f sources.f -Mdir obj_dir -o tb_rv_sys
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/tb_rv_sys > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "^All tests passed$" "$LOG"; then
   exit 0
fi
echo "Pass line not found in $LOG"
exit 1
